//--- logic/scanPkg.sv
`default_nettype none

package scanPkg;

	// Scanner FSM states
	typedef enum logic [1:0] {
		IDLE     = 2'b00,
		ACTIVE   = 2'b01,
		STANDBY  = 2'b10,
		TRANSFER = 2'b11
	} scanState;

	// Host input codes, 2'b11 is ignored
	typedef enum logic [1:0] {
		HOST_NOP   = 2'b00,
		START_SCAN = 2'b01,
		PEER_HALF  = 2'b10  // Other buffer at 50%
	} hostCmd;

	// Downlink command words
	localparam logic [7:0] CMD_READY_SOON = 8'd2;  // 70% full
	localparam logic [7:0] CMD_START_PEER = 8'd3;  // 80% full
	localparam logic [7:0] CMD_FULL       = 8'd4;  // 90% full
	localparam logic [7:0] CMD_TRANSFER   = 8'd7;  // Data word follows

	// Fill counter and thresholds
	localparam int FILL_BITS = 4;
	localparam logic [FILL_BITS-1:0] FILL_WARN = 4'd7;
	localparam logic [FILL_BITS-1:0] FILL_HIGH = 4'd8;
	localparam logic [FILL_BITS-1:0] FILL_FULL = 4'd9;

	localparam int TICK_DIV = 8;  // Clocks per fill tick

endpackage

`default_nettype wire

//--- logic/linkPkg.sv
`default_nettype none

package linkPkg;

	localparam int WORD_BITS = 8;

	// Data word layout, fill level in the low bits
	typedef struct packed {
		logic [WORD_BITS-scanPkg::FILL_BITS-1:0] pad;  // Always zero
		logic [scanPkg::FILL_BITS-1:0]           fill;
	} dataView;

	// One link word, read as a command or as data
	typedef union packed {
		logic [WORD_BITS-1:0] cmd;
		dataView              data;
	} linkWord;

	// Scanner request toward the arbiter
	typedef struct packed {
		logic    pending;  // Held until granted
		logic    isData;   // Selects the union view
		linkWord word;
	} wordReq;

	// Serial link output
	typedef struct packed {
		logic valid;   // Bit strobe
		logic data;
		logic source;  // 0 = scanner A, 1 = scanner B
	} linkBit;

endpackage

`default_nettype wire

//--- logic/scanner.sv
`timescale 1ns/1ps
`default_nettype none

module scanner (
	input  wire                    clk,
	input  wire                    rst,
	input  wire scanPkg::hostCmd   host,
	input  wire                    linkReady,
	input  wire                    grant,
	output linkPkg::wordReq        req
);

	localparam int DIV_BITS = $clog2(scanPkg::TICK_DIV);
	localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(scanPkg::TICK_DIV - 1);

	scanPkg::scanState state;
	logic [scanPkg::FILL_BITS-1:0] fill;
	logic [scanPkg::FILL_BITS-1:0] fillNext;
	logic [DIV_BITS-1:0] divCount;
	logic fillTick;
	logic peerPrev;
	logic peerEdge;
	logic xferTaken;
	logic abortNow;

	function automatic linkPkg::wordReq cmdReq(input logic [linkPkg::WORD_BITS-1:0] code);
		linkPkg::wordReq r;
		r.pending = 1'b1;
		r.isData = 1'b0;
		r.word.cmd = code;
		return r;
	endfunction

	function automatic linkPkg::wordReq dataReq(input logic [scanPkg::FILL_BITS-1:0] level);
		linkPkg::wordReq r;
		r.pending = 1'b1;
		r.isData = 1'b1;
		r.word.data.pad = '0;
		r.word.data.fill = level;
		return r;
	endfunction

	// Fill only advances while nothing waits on the link
	assign fillTick = (divCount == DIV_LAST) && (state == scanPkg::ACTIVE) && !req.pending;
	assign fillNext = fill + 1'b1;

	// New PEER_HALF only, a held code from STANDBY must not abort
	assign peerEdge = (host == scanPkg::PEER_HALF) && !peerPrev;

	// CMD_TRANSFER already granted, or granted right now
	assign xferTaken = req.isData ||
		((req.word.cmd == scanPkg::CMD_TRANSFER) && (!req.pending || grant));

	assign abortNow = (state == scanPkg::TRANSFER) && peerEdge && !xferTaken;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= scanPkg::IDLE;
			fill <= '0;
			divCount <= '0;
			peerPrev <= 1'b0;
			req.pending <= 1'b0;
		end else begin
			divCount <= (divCount == DIV_LAST) ? '0 : divCount + 1'b1;  // Fill rate divider
			peerPrev <= (host == scanPkg::PEER_HALF);

			if (grant)
				req.pending <= 1'b0;  // Word taken by the transmitter

			case (state)
				scanPkg::IDLE: begin
					if (host == scanPkg::START_SCAN)
						state <= scanPkg::ACTIVE;
				end

				scanPkg::ACTIVE: begin
					if (fillTick) begin
						fill <= fillNext;
						if (fillNext == scanPkg::FILL_WARN) begin
							req <= cmdReq(scanPkg::CMD_READY_SOON);
						end else if (fillNext == scanPkg::FILL_HIGH) begin
							req <= cmdReq(scanPkg::CMD_START_PEER);
						end else if (fillNext == scanPkg::FILL_FULL) begin
							req <= cmdReq(scanPkg::CMD_FULL);
							state <= linkReady ? scanPkg::TRANSFER : scanPkg::STANDBY;
						end
					end
				end

				scanPkg::STANDBY: begin
					if (linkReady || host == scanPkg::PEER_HALF)
						state <= scanPkg::TRANSFER;
				end

				scanPkg::TRANSFER: begin
					if (abortNow) begin
						req.pending <= 1'b0;
						fill <= '0;
						state <= scanPkg::IDLE;
					end else if (!req.pending) begin
						// Last granted word tells which step comes next
						if (req.isData) begin
							fill <= '0;  // Buffer drained
							state <= scanPkg::IDLE;
						end else if (req.word.cmd == scanPkg::CMD_TRANSFER) begin
							req <= dataReq(fill);
						end else begin
							req <= cmdReq(scanPkg::CMD_TRANSFER);  // After FULL
						end
					end
				end

				default: state <= scanPkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/linkArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module linkArbiter (
	input  wire                    clk,
	input  wire                    rst,
	input  wire linkPkg::wordReq   reqA,
	input  wire linkPkg::wordReq   reqB,
	input  wire                    busy,
	output logic                   grantA,
	output logic                   grantB,
	output logic                   load,
	output linkPkg::linkWord       loadWord,
	output logic                   loadSource
);

	logic lastB;  // Scanner B won the previous grant
	logic pickB;

	// B wins when alone or when A went last
	assign pickB = reqB.pending && (!reqA.pending || !lastB);

	// One grant per idle cycle with a pending request
	assign load = !busy && (reqA.pending || reqB.pending);

	assign grantA = load && !pickB;
	assign grantB = load && pickB;

	assign loadWord = pickB ? reqB.word : reqA.word;
	assign loadSource = pickB;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastB <= 1'b0;
		end else if (load) begin
			lastB <= pickB;
		end
	end

endmodule

`default_nettype wire

//--- logic/serialTx.sv
`timescale 1ns/1ps
`default_nettype none

module serialTx (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     load,
	input  wire linkPkg::linkWord   loadWord,
	input  wire                     loadSource,
	output logic                    busy,
	output linkPkg::linkBit         out
);

	localparam int CNT_BITS = $clog2(linkPkg::WORD_BITS);
	localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(linkPkg::WORD_BITS - 1);

	logic [linkPkg::WORD_BITS-1:0] shiftReg;
	logic [CNT_BITS-1:0] bitCount;
	logic srcReg;

	// Control path
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			bitCount <= '0;
		end else if (load) begin
			busy <= 1'b1;  // MSB goes out next cycle
			bitCount <= '0;
		end else if (busy) begin
			bitCount <= bitCount + 1'b1;
			if (bitCount == LAST_BIT)
				busy <= 1'b0;  // Eighth bit done
		end
	end

	// Payload, shifted left so the MSB is always on the line
	always_ff @(posedge clk) begin
		if (load) begin
			shiftReg <= loadWord;
			srcReg <= loadSource;
		end else if (busy) begin
			shiftReg <= {shiftReg[linkPkg::WORD_BITS-2:0], 1'b0};
		end
	end

	assign out = '{
		valid:  busy,
		data:   shiftReg[linkPkg::WORD_BITS-1],
		source: srcReg
	};

endmodule

`default_nettype wire

//--- logic/scanSystem.sv
`timescale 1ns/1ps
`default_nettype none

module scanSystem (
	input  wire                    clk,
	input  wire                    rst,
	input  wire scanPkg::hostCmd   hostA,
	input  wire scanPkg::hostCmd   hostB,
	input  wire                    linkReady,
	output linkPkg::linkBit        link
);

	linkPkg::wordReq reqA;
	linkPkg::wordReq reqB;
	linkPkg::linkWord loadWord;
	logic grantA;
	logic grantB;
	logic load;
	logic loadSource;
	logic busy;

	scanner scanA (  // Source 0
		.clk(clk),
		.rst(rst),
		.host(hostA),
		.linkReady(linkReady),
		.grant(grantA),
		.req(reqA)
	);

	scanner scanB (  // Source 1
		.clk(clk),
		.rst(rst),
		.host(hostB),
		.linkReady(linkReady),
		.grant(grantB),
		.req(reqB)
	);

	linkArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.reqA(reqA),
		.reqB(reqB),
		.busy(busy),
		.grantA(grantA),
		.grantB(grantB),
		.load(load),
		.loadWord(loadWord),
		.loadSource(loadSource)
	);

	serialTx tx (
		.clk(clk),
		.rst(rst),
		.load(load),
		.loadWord(loadWord),
		.loadSource(loadSource),
		.busy(busy),
		.out(link)
	);

endmodule

`default_nettype wire

//--- test/linkMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module linkMonitor (
	input  wire                            clk,
	input  wire                            rst,
	input  wire linkPkg::linkBit           link,
	output logic                           wordDone,   // One cycle per assembled word
	output logic [linkPkg::WORD_BITS-1:0]  word,
	output logic                           wordSource,
	output logic                           frameError  // Gap inside a word or tag change
);

	logic [linkPkg::WORD_BITS-1:0] shiftReg;
	logic [2:0] bitCount;
	logic srcTag;

	always_ff @(posedge clk) begin
		if (rst) begin
			bitCount <= '0;
			wordDone <= 1'b0;
			frameError <= 1'b0;
		end else begin
			wordDone <= 1'b0;
			frameError <= 1'b0;
			if (link.valid) begin
				// First bit after a gap or after a full word opens a new word
				if (bitCount == 3'd0)
					srcTag <= link.source;
				else if (link.source != srcTag)
					frameError <= 1'b1;  // Tag must hold for the whole word
				shiftReg <= {shiftReg[linkPkg::WORD_BITS-2:0], link.data};  // MSB first
				if (bitCount == 3'd7) begin
					wordDone <= 1'b1;
					word <= {shiftReg[linkPkg::WORD_BITS-2:0], link.data};
					wordSource <= srcTag;
					bitCount <= '0;
				end else begin
					bitCount <= bitCount + 1'b1;
				end
			end else if (bitCount != 3'd0) begin
				frameError <= 1'b1;  // Word cut short
				bitCount <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- test/scanSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module scanSystemTb;

	localparam int PERIOD = 40;
	localparam int unsigned SEED = 32'h2b50_6995;
	localparam int SEQ_WORDS = 5;
	localparam int SCENARIOS = 6;
	localparam int SCENARIO_CYCLES = 10 * scanPkg::TICK_DIV + SEQ_WORDS * 9;  // Fill plus words
	localparam int LIMIT_CYCLES = 2 * SCENARIOS * SCENARIO_CYCLES;

	// Words of one complete scan
	localparam logic [7:0] SEQ [SEQ_WORDS] = '{
		scanPkg::CMD_READY_SOON,
		scanPkg::CMD_START_PEER,
		scanPkg::CMD_FULL,
		scanPkg::CMD_TRANSFER,
		{4'b0000, scanPkg::FILL_FULL}
	};

	logic clk;
	logic rst;
	scanPkg::hostCmd hostA;
	scanPkg::hostCmd hostB;
	logic linkReady;
	linkPkg::linkBit link;
	logic wordDone;
	logic [linkPkg::WORD_BITS-1:0] word;
	logic wordSource;
	logic frameError;

	logic [7:0] expA[$];
	logic [7:0] expB[$];
	int wantA = 0;
	int wantB = 0;
	int rxA = 0;
	int rxB = 0;
	int wordErrors = 0;
	int frameErrors = 0;
	int linkErrors = 0;
	int arbErrors = 0;
	logic lastSource;
	logic haveLast;

	scanSystem UUT (
		.clk(clk),
		.rst(rst),
		.hostA(hostA),
		.hostB(hostB),
		.linkReady(linkReady),
		.link(link)
	);

	linkMonitor mon (
		.clk(clk),
		.rst(rst),
		.link(link),
		.wordDone(wordDone),
		.word(word),
		.wordSource(wordSource),
		.frameError(frameError)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		logic hasExp;
		logic [7:0] expWord;
		hasExp = 1'b0;
		expWord = '0;
		// A strobe needs an outstanding word
		assert (link.valid !== 1'b1 || expA.size() + expB.size() > 0) else begin
			$display("Link strobed a bit while no word was expected at %0t", $time);
			linkErrors++;
		end
		if (!rst) begin
			assert (!frameError) else begin
				$display("Framing broken on the link at %0t", $time);
				frameErrors++;
			end
			if (wordDone) begin
				if (wordSource) begin
					hasExp = expB.size() > 0;
					if (hasExp)
						expWord = expB.pop_front();
					rxB <= rxB + 1;
				end else begin
					hasExp = expA.size() > 0;
					if (hasExp)
						expWord = expA.pop_front();
					rxA <= rxA + 1;
				end
				assert (hasExp) else begin
					$display("Word %h from source %0d arrived unexpected", word, wordSource);
					linkErrors++;
				end
				assert (!hasExp || word == expWord) else begin
					$display("** Error: word = 0x%h, expected 0x%h (source %0d)",
						word, expWord, wordSource);
					wordErrors++;
				end
			end
			if (UUT.load) begin
				if (haveLast && UUT.reqA.pending && UUT.reqB.pending) begin
					assert (UUT.loadSource != lastSource) else begin  // Round-robin
						$display("** Error: loadSource = 0x%h, expected 0x%h",
							UUT.loadSource, !lastSource);
						arbErrors++;
					end
				end
				lastSource <= UUT.loadSource;
				haveLast <= 1'b1;
			end
		end else begin
			haveLast <= 1'b0;
		end
	end

	task automatic expectWords(input logic toB, input int first, input int last);
		int i;
		for (i = first; i <= last; i++) begin
			if (toB) begin
				expB.push_back(SEQ[i]);
				wantB++;
			end else begin
				expA.push_back(SEQ[i]);
				wantA++;
			end
		end
	endtask

	// Drives both host codes for a random hold before returning to no-op
	task automatic driveHosts(input scanPkg::hostCmd codeA, input scanPkg::hostCmd codeB);
		int hold;
		hold = $urandom_range(4, 1);
		hostA <= codeA;
		hostB <= codeB;
		repeat (hold) @(posedge clk);
		hostA <= scanPkg::HOST_NOP;
		hostB <= scanPkg::HOST_NOP;
	endtask

	task automatic waitDrained();
		while (rxA < wantA || rxB < wantB)
			@(posedge clk);
	endtask

	task automatic waitCycles(input int cycles);
		repeat (cycles) @(posedge clk);
	endtask

	task automatic printCounts();
		$display("Error counts: word %0d, framing %0d, link %0d, arbitration %0d",
			wordErrors, frameErrors, linkErrors, arbErrors);
	endtask

	initial begin
		int offset;
		void'($urandom(SEED));
		rst <= 1'b1;
		hostA <= scanPkg::HOST_NOP;
		hostB <= scanPkg::HOST_NOP;
		linkReady <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		waitCycles(32);  // Quiet link

		linkReady <= 1'b1;  // Scanner A alone runs the full sequence
		expectWords(1'b0, 0, 4);
		driveHosts(scanPkg::START_SCAN, scanPkg::HOST_NOP);
		waitDrained();
		waitCycles(16);

		linkReady <= 1'b0;  // Scanner B stops in STANDBY
		expectWords(1'b1, 0, 2);
		driveHosts(scanPkg::HOST_NOP, scanPkg::START_SCAN);
		waitDrained();
		waitCycles(48);
		expectWords(1'b1, 3, 4);
		linkReady <= 1'b1;
		waitDrained();
		waitCycles(16);

		expectWords(1'b0, 0, 4);  // Shared link with a random start offset
		expectWords(1'b1, 0, 4);
		driveHosts(scanPkg::START_SCAN, scanPkg::HOST_NOP);
		offset = $urandom_range(31, 0);
		waitCycles(offset);
		driveHosts(scanPkg::HOST_NOP, scanPkg::START_SCAN);
		waitDrained();
		waitCycles(16);

		expectWords(1'b0, 0, 4);  // Same start so the requests collide
		expectWords(1'b1, 0, 4);
		driveHosts(scanPkg::START_SCAN, scanPkg::START_SCAN);
		waitDrained();
		waitCycles(16);

		linkReady <= 1'b0;  // PEER_HALF in STANDBY moves on
		expectWords(1'b0, 0, 2);
		driveHosts(scanPkg::START_SCAN, scanPkg::HOST_NOP);
		waitDrained();
		expectWords(1'b0, 3, 4);
		driveHosts(scanPkg::PEER_HALF, scanPkg::HOST_NOP);
		waitDrained();
		waitCycles(16);

		// PEER_HALF while FULL is on the line drops the TRANSFER word
		linkReady <= 1'b1;
		expectWords(1'b0, 0, 2);
		driveHosts(scanPkg::START_SCAN, scanPkg::HOST_NOP);
		while (rxA < wantA - 1)
			@(posedge clk);
		while (link.valid !== 1'b1)
			@(posedge clk);
		driveHosts(scanPkg::PEER_HALF, scanPkg::HOST_NOP);
		waitDrained();
		waitCycles(48);
		expectWords(1'b0, 0, 4);  // Restart from an empty buffer
		driveHosts(scanPkg::START_SCAN, scanPkg::HOST_NOP);
		waitDrained();
		waitCycles(16);

		printCounts();
		if (wordErrors + frameErrors + linkErrors + arbErrors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
		printCounts();
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/scanPkg.sv
logic/linkPkg.sv
logic/scanner.sv
logic/linkArbiter.sv
logic/serialTx.sv
logic/scanSystem.sv
test/linkMonitor.sv
test/scanSystemTb.sv

//--- Makefile
TOP := scanSystemTb
SRCS := $(shell cat src.f)

all: run

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	grep -q 'All tests passed!' sim.log

check:
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean
